// File: verilog/dmr_pkg.sv
// ----------------------------------------
// DMR cluster package
// Opcodes, widths and register map shared
// by the hart cluster and its testbench
// ----------------------------------------

package dmr_pkg;

  // Cluster shape
  localparam int unsigned NumHarts      = 2;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned ErrCountWidth = 8;

  // Wishbone word bus
  localparam int unsigned BusWidth   = 32;
  localparam int unsigned WbAdrWidth = 2;

  // Hart operations
  typedef enum logic [1:0] {
    OP_ADD    = 2'd0,
    OP_XOR    = 2'd1,
    OP_ROTADD = 2'd2,
    OP_CLR    = 2'd3
  } opcode_e;

  // Register word addresses
  localparam logic [WbAdrWidth-1:0] RegCtrl   = 2'd0;
  localparam logic [WbAdrWidth-1:0] RegStatus = 2'd1;
  localparam logic [WbAdrWidth-1:0] RegId     = 2'd2;

  // Control register bits
  localparam int unsigned CtrlDmrEn  = 0;
  localparam int unsigned CtrlInject = 1;

  // Status register fields
  localparam int unsigned StatusSticky   = 0;
  localparam int unsigned StatusCountLsb = 8;

  // Reads back as "DMR2"
  localparam logic [BusWidth-1:0] IdValue = 32'h444D_5232;

endpackage

// File: verilog/op_stream_if.sv
// ----------------------------------------
// Hart operation stream
// One operation per cycle plus setback
// ----------------------------------------

interface op_stream_if;

  import dmr_pkg::*;

  logic                 valid;
  opcode_e              opcode;
  logic [DataWidth-1:0] operand;
  // Clears the hart pipeline and accumulator
  logic                 setback;

  modport source (
    output valid,
    output opcode,
    output operand,
    output setback
  );

  modport sink (
    input valid,
    input opcode,
    input operand,
    input setback
  );

endinterface

// File: verilog/hart_core.sv
// ----------------------------------------
// Accumulator hart
// Decode stage then execute stage, one
// operation per cycle
// ----------------------------------------

module hart_core (
  input  logic                          clk_i,
  input  logic                          reset_i,
  op_stream_if.sink                     op,
  output logic                          res_valid_o,
  output logic [dmr_pkg::DataWidth-1:0] res_data_o
);

  import dmr_pkg::*;

  // Decode stage
  logic                 dec_valid_q;
  opcode_e              dec_opcode_q;
  logic [DataWidth-1:0] dec_operand_q;

  // Execute stage
  logic [DataWidth-1:0] acc_q;
  logic [DataWidth-1:0] acc_next;
  logic                 res_valid_q;

  // Stage one takes the operation in the cycle it is valid
  always_ff @(posedge clk_i) begin
    if (reset_i || op.setback) begin
      dec_valid_q <= 1'b0;
    end else begin
      dec_valid_q <= op.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op.valid) begin
      dec_opcode_q  <= op.opcode;
      dec_operand_q <= op.operand;
    end
  end

  // Apply the decoded operation to the accumulator
  always_comb begin
    acc_next = acc_q;
    unique case (dec_opcode_q)
      OP_ADD: begin
        acc_next = acc_q + dec_operand_q;
      end
      OP_XOR: begin
        acc_next = acc_q ^ dec_operand_q;
      end
      OP_ROTADD: begin
        // Rotate left by one first
        acc_next = {acc_q[DataWidth-2:0], acc_q[DataWidth-1]} + dec_operand_q;
      end
      OP_CLR: begin
        acc_next = '0;
      end
      default: begin
        acc_next = acc_q;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || op.setback) begin
      acc_q       <= '0;
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= dec_valid_q;
      if (dec_valid_q) begin
        acc_q <= acc_next;
      end
    end
  end

  // Result is the freshly updated accumulator
  assign res_valid_o = res_valid_q;
  assign res_data_o  = acc_q;

endmodule

// File: verilog/dmr_regs.sv
// ----------------------------------------
// DMR register block
// Wishbone classic slave with control,
// status and identification words
// ----------------------------------------

module dmr_regs (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic [dmr_pkg::WbAdrWidth-1:0] wb_adr_i,
  input  logic [dmr_pkg::BusWidth-1:0]   wb_dat_i,
  output logic [dmr_pkg::BusWidth-1:0]   wb_dat_o,
  output logic                           wb_ack_o,
  output logic                           dmr_en_o,
  output logic                           inject_o,
  input  logic                           mismatch_i
);

  import dmr_pkg::*;

  logic                     wb_req;
  logic                     wb_wr;
  logic [BusWidth-1:0]      rdata;

  logic                     dmr_en_q;
  logic                     inject_q;
  logic                     sticky_q;
  logic [ErrCountWidth-1:0] count_q;
  logic                     status_clr;

  // New request only while no ack is out
  assign wb_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wb_wr  = wb_req && wb_we_i;

  assign status_clr = wb_wr && (wb_adr_i == RegStatus) && wb_dat_i[StatusSticky];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= wb_req;
    end
  end

  // Control word
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dmr_en_q <= 1'b0;
      inject_q <= 1'b0;
    end else begin
      inject_q <= 1'b0;
      if (wb_wr && (wb_adr_i == RegCtrl)) begin
        dmr_en_q <= wb_dat_i[CtrlDmrEn];
        inject_q <= wb_dat_i[CtrlInject];
      end
    end
  end

  // Sticky flag and saturating mismatch counter
  always_ff @(posedge clk_i) begin
    if (reset_i || status_clr) begin
      sticky_q <= 1'b0;
      count_q  <= '0;
    end else if (mismatch_i) begin
      sticky_q <= 1'b1;
      if (count_q != '1) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Read mux, unmapped words read as zero
  always_comb begin
    rdata = '0;
    case (wb_adr_i)
      RegCtrl: begin
        rdata[CtrlDmrEn] = dmr_en_q;
      end
      RegStatus: begin
        rdata[StatusSticky]                        = sticky_q;
        rdata[StatusCountLsb +: ErrCountWidth]     = count_q;
      end
      RegId: begin
        rdata = IdValue;
      end
      default: begin
        rdata = '0;
      end
    endcase
  end

  // Data is held alongside ack
  always_ff @(posedge clk_i) begin
    if (wb_req) begin
      wb_dat_o <= rdata;
    end
  end

  assign dmr_en_o = dmr_en_q;
  assign inject_o = inject_q;

endmodule

// File: verilog/dmr_unit.sv
// ----------------------------------------
// Dual modular redundancy unit
// Routes operations to the harts, injects
// faults and compares lockstep results
// ----------------------------------------

module dmr_unit (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  logic                                                  dmr_en_i,
  input  logic                                                  inject_i,
  output logic                                                  mismatch_o,
  input  logic              [dmr_pkg::NumHarts-1:0]                         op_valid_i,
  input  dmr_pkg::opcode_e  [dmr_pkg::NumHarts-1:0]                         op_code_i,
  input  logic              [dmr_pkg::NumHarts-1:0][dmr_pkg::DataWidth-1:0] op_data_i,
  op_stream_if.source                                           hart0_op_o,
  op_stream_if.source                                           hart1_op_o,
  input  logic              [dmr_pkg::NumHarts-1:0]                         hart_res_valid_i,
  input  logic              [dmr_pkg::NumHarts-1:0][dmr_pkg::DataWidth-1:0] hart_res_data_i,
  output logic              [dmr_pkg::NumHarts-1:0]                         res_valid_o,
  output logic              [dmr_pkg::NumHarts-1:0][dmr_pkg::DataWidth-1:0] res_data_o
);

  import dmr_pkg::*;

  logic                 dmr_en_q;
  logic                 setback_q;
  logic                 mismatch_q;
  logic                 fault_pending_q;
  logic                 fault_used;
  logic                 compare_en;
  logic                 results_differ;
  logic                 mismatch_det;
  logic [DataWidth-1:0] fault_mask;

  // Fault lands on the next lockstep operation of port 0
  assign fault_used = fault_pending_q && dmr_en_i && op_valid_i[0] && !setback_q;
  assign fault_mask = DataWidth'(fault_pending_q && dmr_en_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fault_pending_q <= 1'b0;
    end else if (inject_i) begin
      fault_pending_q <= 1'b1;
    end else if (fault_used) begin
      fault_pending_q <= 1'b0;
    end
  end

  // Hart 0 always serves port 0
  assign hart0_op_o.valid   = op_valid_i[0];
  assign hart0_op_o.opcode  = op_code_i[0];
  assign hart0_op_o.operand = op_data_i[0];
  assign hart0_op_o.setback = setback_q;

  // Hart 1 mirrors port 0 in lockstep
  always_comb begin
    if (dmr_en_i) begin
      hart1_op_o.valid   = op_valid_i[0];
      hart1_op_o.opcode  = op_code_i[0];
      hart1_op_o.operand = op_data_i[0] ^ fault_mask;
    end else begin
      hart1_op_o.valid   = op_valid_i[1];
      hart1_op_o.opcode  = op_code_i[1];
      hart1_op_o.operand = op_data_i[1];
    end
  end
  assign hart1_op_o.setback = setback_q;

  // Compare only once lockstep has settled and no setback is under way
  assign compare_en = dmr_en_i && dmr_en_q && !setback_q;

  assign results_differ = (hart_res_valid_i[0] != hart_res_valid_i[1]) ||
                          (hart_res_valid_i[0] && (hart_res_data_i[0] != hart_res_data_i[1]));

  assign mismatch_det = compare_en && results_differ;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dmr_en_q   <= 1'b0;
      setback_q  <= 1'b0;
      mismatch_q <= 1'b0;
    end else begin
      dmr_en_q   <= dmr_en_i;
      mismatch_q <= mismatch_det;
      // Resync on a mismatch or any mode change
      setback_q  <= mismatch_det || (dmr_en_i != dmr_en_q);
    end
  end

  assign mismatch_o = mismatch_q;

  // Port 1 is silent while its hart shadows hart 0
  assign res_valid_o[0] = hart_res_valid_i[0];
  assign res_valid_o[1] = hart_res_valid_i[1] && !dmr_en_i;
  assign res_data_o     = hart_res_data_i;

endmodule

// File: verilog/hart_cluster.sv
// ----------------------------------------
// Two-hart DMR cluster top level
// Register block, redundancy unit and
// two accumulator harts
// ----------------------------------------

module hart_cluster (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  input  logic                                                 wb_cyc_i,
  input  logic                                                 wb_stb_i,
  input  logic                                                 wb_we_i,
  input  logic             [dmr_pkg::WbAdrWidth-1:0]           wb_adr_i,
  input  logic             [dmr_pkg::BusWidth-1:0]             wb_dat_i,
  output logic             [dmr_pkg::BusWidth-1:0]             wb_dat_o,
  output logic                                                 wb_ack_o,
  input  logic             [dmr_pkg::NumHarts-1:0]                         op_valid_i,
  input  dmr_pkg::opcode_e [dmr_pkg::NumHarts-1:0]                         op_code_i,
  input  logic             [dmr_pkg::NumHarts-1:0][dmr_pkg::DataWidth-1:0] op_data_i,
  output logic             [dmr_pkg::NumHarts-1:0]                         res_valid_o,
  output logic             [dmr_pkg::NumHarts-1:0][dmr_pkg::DataWidth-1:0] res_data_o,
  output logic                                                 redundancy_en_o,
  output logic                                                 mismatch_o
);

  import dmr_pkg::*;

  logic                                dmr_en;
  logic                                inject;
  logic                                mismatch;
  logic [NumHarts-1:0]                 hart_res_valid;
  logic [NumHarts-1:0][DataWidth-1:0]  hart_res_data;

  op_stream_if op_if0 ();
  op_stream_if op_if1 ();

  dmr_regs i_dmr_regs (
    .clk_i      ( clk_i    ),
    .reset_i    ( reset_i  ),
    .wb_cyc_i   ( wb_cyc_i ),
    .wb_stb_i   ( wb_stb_i ),
    .wb_we_i    ( wb_we_i  ),
    .wb_adr_i   ( wb_adr_i ),
    .wb_dat_i   ( wb_dat_i ),
    .wb_dat_o   ( wb_dat_o ),
    .wb_ack_o   ( wb_ack_o ),
    .dmr_en_o   ( dmr_en   ),
    .inject_o   ( inject   ),
    .mismatch_i ( mismatch )
  );

  dmr_unit i_dmr_unit (
    .clk_i            ( clk_i          ),
    .reset_i          ( reset_i        ),
    .dmr_en_i         ( dmr_en         ),
    .inject_i         ( inject         ),
    .mismatch_o       ( mismatch       ),
    .op_valid_i       ( op_valid_i     ),
    .op_code_i        ( op_code_i      ),
    .op_data_i        ( op_data_i      ),
    .hart0_op_o       ( op_if0.source  ),
    .hart1_op_o       ( op_if1.source  ),
    .hart_res_valid_i ( hart_res_valid ),
    .hart_res_data_i  ( hart_res_data  ),
    .res_valid_o      ( res_valid_o    ),
    .res_data_o       ( res_data_o     )
  );

  hart_core i_hart0 (
    .clk_i       ( clk_i             ),
    .reset_i     ( reset_i           ),
    .op          ( op_if0.sink       ),
    .res_valid_o ( hart_res_valid[0] ),
    .res_data_o  ( hart_res_data[0]  )
  );

  hart_core i_hart1 (
    .clk_i       ( clk_i             ),
    .reset_i     ( reset_i           ),
    .op          ( op_if1.sink       ),
    .res_valid_o ( hart_res_valid[1] ),
    .res_data_o  ( hart_res_data[1]  )
  );

  assign redundancy_en_o = dmr_en;
  assign mismatch_o      = mismatch;

endmodule

// File: verif/tb_hart_cluster.sv
// ----------------------------------------
// DMR hart cluster testbench
// Drives random operations and register
// accesses, checks against a port model
// ----------------------------------------

module tb_hart_cluster;

  import dmr_pkg::*;

  // Generous bound over the length of all tests
  localparam int MaxCycles = 3000;

  logic                               clk_i;
  logic                               reset_i;
  logic                               wb_cyc_i;
  logic                               wb_stb_i;
  logic                               wb_we_i;
  logic [WbAdrWidth-1:0]              wb_adr_i;
  logic [BusWidth-1:0]                wb_dat_i;
  logic [BusWidth-1:0]                wb_dat_o;
  logic                               wb_ack_o;
  logic [NumHarts-1:0]                op_valid_i;
  opcode_e [NumHarts-1:0]             op_code_i;
  logic [NumHarts-1:0][DataWidth-1:0] op_data_i;
  logic [NumHarts-1:0]                res_valid_o;
  logic [NumHarts-1:0][DataWidth-1:0] res_data_o;
  logic                               redundancy_en_o;
  logic                               mismatch_o;

  logic [15:0]          lfsr_state;
  logic                 lockstep_exp;
  logic [DataWidth-1:0] model_acc [NumHarts];
  // Expected result pipe where index 1 is due now
  logic                 exp_valid [NumHarts][2];
  logic [DataWidth-1:0] exp_data  [NumHarts][2];
  int                   errors;
  int                   tests_passed;
  int                   tests_failed;
  int                   mismatch_seen;
  int                   cycle_count;
  int                   test_err_start;
  logic [BusWidth-1:0]  rd;

  hart_cluster dut_i (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .wb_cyc_i        ( wb_cyc_i        ),
    .wb_stb_i        ( wb_stb_i        ),
    .wb_we_i         ( wb_we_i         ),
    .wb_adr_i        ( wb_adr_i        ),
    .wb_dat_i        ( wb_dat_i        ),
    .wb_dat_o        ( wb_dat_o        ),
    .wb_ack_o        ( wb_ack_o        ),
    .op_valid_i      ( op_valid_i      ),
    .op_code_i       ( op_code_i       ),
    .op_data_i       ( op_data_i       ),
    .res_valid_o     ( res_valid_o     ),
    .res_data_o      ( res_data_o      ),
    .redundancy_en_o ( redundancy_en_o ),
    .mismatch_o      ( mismatch_o      )
  );

  initial begin
    clk_i = 1'b0;
  end
  always #2 clk_i = ~clk_i;

  // 16-bit Galois LFSR stepped once per bit taken
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Accumulator rules for the four opcodes
  function automatic logic [DataWidth-1:0] apply_op(input logic [DataWidth-1:0] acc,
                                                    input opcode_e op,
                                                    input logic [DataWidth-1:0] data);
    case (op)
      OP_ADD:    return acc + data;
      OP_XOR:    return acc ^ data;
      OP_ROTADD: return {acc[DataWidth-2:0], acc[DataWidth-1]} + data;
      default:   return '0;
    endcase
  endfunction

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("Fail %0t: %s expected %h got %h", $time, what, exp, got);
      errors++;
    end
  endtask

  task automatic wait_ack();
    int waited;
    waited = 0;
    // First falling edge lies in the request cycle itself
    @(negedge clk_i);
    while (!wb_ack_o && waited < 8) begin
      @(negedge clk_i);
      waited++;
    end
    assert (wb_ack_o && waited == 1) else begin
      $display("Fail %0t: ack expected after 1 cycle, seen after %0d", $time, waited);
      errors++;
    end
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [WbAdrWidth-1:0] adr, input logic [BusWidth-1:0] dat);
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wait_ack();
  endtask

  task automatic wb_read(input logic [WbAdrWidth-1:0] adr, output logic [BusWidth-1:0] dat);
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = adr;
    wait_ack();
    dat = wb_dat_o;
  endtask

  // Random operations on both ports
  task automatic run_ops(input int n, input bit force_valid);
    int          i;
    int          p;
    logic [31:0] r;
    for (i = 0; i < n; i++) begin
      @(posedge clk_i);
      #1;
      for (p = 0; p < NumHarts; p++) begin
        r = rand_bits(2);
        op_valid_i[p] = |r[1:0];
        r = rand_bits(2);
        op_code_i[p] = opcode_e'(r[1:0]);
        op_data_i[p] = rand_bits(32);
      end
      // Port 0 gets a valid op other than clear
      if (force_valid) begin
        op_valid_i[0] = 1'b1;
        if (op_code_i[0] == OP_CLR) begin
          op_code_i[0] = OP_ADD;
        end
      end
    end
    @(posedge clk_i);
    #1;
    op_valid_i = '0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic zero_models();
    model_acc[0] = '0;
    model_acc[1] = '0;
  endtask

  task automatic end_test(input string name);
    if (errors == test_err_start) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - test_err_start);
    end
    test_err_start = errors;
  endtask

  // Result check and model update at the falling edge
  always @(negedge clk_i) begin
    int   p;
    logic v;
    if (reset_i) begin
      for (p = 0; p < NumHarts; p++) begin
        exp_valid[p][0] = 1'b0;
        exp_valid[p][1] = 1'b0;
      end
    end else begin
      if (mismatch_o) begin
        mismatch_seen++;
      end
      for (p = 0; p < NumHarts; p++) begin
        assert (res_valid_o[p] === exp_valid[p][1]) else begin
          $display("Fail %0t: port %0d valid expected %b got %b", $time, p,
                   exp_valid[p][1], res_valid_o[p]);
          errors++;
        end
        if (exp_valid[p][1]) begin
          assert (res_data_o[p] === exp_data[p][1]) else begin
            $display("Fail %0t: port %0d data expected %h got %h", $time, p,
                     exp_data[p][1], res_data_o[p]);
            errors++;
          end
        end
        exp_valid[p][1] = exp_valid[p][0];
        exp_data[p][1]  = exp_data[p][0];
        v = op_valid_i[p] && !(p == 1 && lockstep_exp);
        if (v) begin
          model_acc[p] = apply_op(model_acc[p], op_code_i[p], op_data_i[p]);
        end
        exp_valid[p][0] = v;
        exp_data[p][0]  = model_acc[p];
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i) wb_ack_o |=> !wb_ack_o)
    else begin
      $display("Fail %0t: ack expected low after one cycle, got high", $time);
      errors++;
    end

  assert property (@(posedge clk_i) disable iff (reset_i) mismatch_o |=> !mismatch_o)
    else begin
      $display("Fail %0t: mismatch expected as single pulse, got two cycles", $time);
      errors++;
    end

  assert property (@(posedge clk_i) disable iff (reset_i) redundancy_en_o |-> !res_valid_o[1])
    else begin
      $display("Fail %0t: port 1 valid expected 0 in lockstep, got 1", $time);
      errors++;
    end

  // Hard stop if the run hangs
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count == MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    int k;
    reset_i        = 1'b1;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_adr_i       = '0;
    wb_dat_i       = '0;
    op_valid_i     = '0;
    op_code_i[0]   = OP_ADD;
    op_code_i[1]   = OP_ADD;
    op_data_i      = '0;
    lfsr_state     = 16'd26443;
    lockstep_exp   = 1'b0;
    errors         = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    mismatch_seen  = 0;
    cycle_count    = 0;
    test_err_start = 0;
    zero_models();
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    wb_read(RegId, rd);
    check_word("id word", IdValue, rd);
    wb_read(RegCtrl, rd);
    check_word("control after reset", 32'd0, rd);
    wb_read(RegStatus, rd);
    check_word("status after reset", 32'd0, rd);
    wb_read(2'd3, rd);
    check_word("unmapped word", 32'd0, rd);
    wb_write(RegId, 32'hFFFF_FFFF);
    wb_read(RegId, rd);
    check_word("id after write", IdValue, rd);
    end_test("register access");

    run_ops(200, 1'b0);
    idle(3);
    end_test("split mode");

    wb_write(RegCtrl, 32'd1 << CtrlDmrEn);
    check_word("redundancy_en_o", 32'd1, {31'd0, redundancy_en_o});
    lockstep_exp = 1'b1;
    idle(3);
    zero_models();
    run_ops(200, 1'b0);
    idle(3);
    check_word("mismatch pulses", 32'd0, mismatch_seen);
    end_test("lockstep entry");

    for (k = 0; k < 4; k++) begin
      wb_write(RegCtrl, (32'd1 << CtrlDmrEn) | (32'd1 << CtrlInject));
      run_ops(1, 1'b1);
      idle(4);
      check_word("mismatch pulses", k + 1, mismatch_seen);
      zero_models();
      if (k == 0) begin
        wb_read(RegStatus, rd);
        check_word("status after one fault", 32'h0000_0101, rd);
        run_ops(50, 1'b0);
        idle(3);
      end
    end
    wb_read(RegStatus, rd);
    check_word("status after four faults", 32'h0000_0401, rd);
    end_test("fault injection");

    wb_write(RegStatus, 32'd1 << StatusSticky);
    wb_read(RegStatus, rd);
    check_word("status after clear", 32'd0, rd);
    wb_write(RegCtrl, 32'd0);
    check_word("redundancy_en_o", 32'd0, {31'd0, redundancy_en_o});
    lockstep_exp = 1'b0;
    idle(3);
    zero_models();
    run_ops(200, 1'b0);
    idle(3);
    end_test("clear and split mode");

    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
verilog/dmr_pkg.sv
verilog/op_stream_if.sv
verilog/hart_core.sv
verilog/dmr_regs.sv
verilog/dmr_unit.sv
verilog/hart_cluster.sv
verif/tb_hart_cluster.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_hart_cluster
RTL_TOP   ?= hart_cluster
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TB PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
